// ==== hilo_unit.f ====
+incdir+rtl
rtl/hilo_pkg.sv
rtl/hilo_exec_if.sv
rtl/apb_hilo_regs.sv
rtl/multiplier.sv
rtl/divider.sv
rtl/hilo_writeback.sv
rtl/hilo_unit_top.sv
tb/tb_hilo_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the HI/LO unit testbench with Verilator and runs it.
# A failing check ends the run with $fatal, so the binary exits nonzero.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_hilo_unit -o tb_hilo_unit -f hilo_unit.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/tb_hilo_unit
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi

exit 0

// ==== tb/tb_hilo_unit.sv ====
`include "hilo_defines.svh"

module tb_hilo_unit
    import hilo_pkg::*;
();

    localparam int W             = `HILO_DATA_W;
    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 16;
    localparam int N_MULT_CORNER = 5;
    localparam int N_MULT_RAND   = 6;
    localparam int N_MAC         = 3;
    localparam int N_DIV_CORNER  = 7;
    localparam int N_DIV_RAND    = 8;
    localparam int NUM_TESTS     = 2*N_MULT_CORNER + 2*N_MULT_RAND + 4*N_MAC
                                   + N_DIV_CORNER + 2*N_DIV_RAND + 4;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * 60 + RESET_CYCLES;

    logic                       clk = 1'b0;
    logic                       rst;
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [`HILO_ADDR_W-1:0]    paddr;
    logic [W-1:0]               pwdata;
    logic [W-1:0]               prdata;
    logic                       pready;
    logic                       pslverr;

    logic [31:0]                lfsr_state = 32'h342c;
    logic [W-1:0]               ref_hi = '0;        // Model of HI/LO.
    logic [W-1:0]               ref_lo = '0;

    hilo_unit_top uut (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus source and reference model.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Taps 32, 22, 2, 1.
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [W-1:0] rand_bits(input int n);
        logic [W-1:0] w;
        w = '0;
        for (int i = 0; i < n; i++)
            w = {w[W-2:0], lfsr_bit()};
        return w;
    endfunction

    function automatic logic [2*W-1:0] ref_mult(input funct_t f, input logic [W-1:0] a,
                                               input logic [W-1:0] b,
                                               input logic [2*W-1:0] acc);
        logic signed [2*W-1:0] sa;
        logic signed [2*W-1:0] sb;
        logic [2*W-1:0]        p;
        sa = {{W{a[W-1]}}, a};
        sb = {{W{b[W-1]}}, b};
        if (f inside {FUNCT_MULT, FUNCT_MADD, FUNCT_MSUB})
            p = sa * sb;
        else
            p = {{W{1'b0}}, a} * {{W{1'b0}}, b};
        case (f)
            FUNCT_MADD, FUNCT_MADDU: return acc + p;
            FUNCT_MSUB, FUNCT_MSUBU: return acc - p;
            default:                 return p;
        endcase
    endfunction

    // Returns {remainder, quotient}.
    function automatic logic [2*W-1:0] ref_divide(input funct_t f, input logic [W-1:0] a,
                                                 input logic [W-1:0] b);
        logic signed [2*W-1:0] sa;
        logic signed [2*W-1:0] sb;
        logic signed [2*W-1:0] q;
        logic signed [2*W-1:0] r;
        if (b == '0)
            return {a, {W{1'b1}}};
        sa = (f == FUNCT_DIV) ? {{W{a[W-1]}}, a} : {{W{1'b0}}, a};
        sb = (f == FUNCT_DIV) ? {{W{b[W-1]}}, b} : {{W{1'b0}}, b};
        q  = sa / sb;                               // Truncates toward zero.
        r  = sa % sb;
        return {r[W-1:0], q[W-1:0]};
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checks and APB transfers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_word(input string what, input logic [W-1:0] got,
                              input logic [W-1:0] want);
        assert (got === want) else begin
            $display("CHECK FAILED at time %0t: %s is %h, expected %h", $time, what, got, want);
            $display("Test FAILED");
            $fatal(1, "Wrong value");
        end
    endtask

    task automatic apb_write(input reg_addr_t addr, input logic [W-1:0] data,
                             output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);                             // Access phase.
        err = pslverr;
        check_word("pready", W'(pready), W'(1));
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input reg_addr_t addr, output logic [W-1:0] data,
                            output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;
        err  = pslverr;
        check_word("pready", W'(pready), W'(1));
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_ok(input reg_addr_t addr, input logic [W-1:0] data);
        logic err;
        apb_write(addr, data, err);
        check_word($sformatf("pslverr of write to %s", addr.name()), W'(err), '0);
    endtask

    task automatic write_refused(input reg_addr_t addr, input logic [W-1:0] data);
        logic err;
        apb_write(addr, data, err);
        check_word($sformatf("pslverr of busy write to %s", addr.name()), W'(err), W'(1));
    endtask

    task automatic read_expect(input reg_addr_t addr, input logic [W-1:0] want,
                               input string what);
        logic [W-1:0] got;
        logic         err;
        apb_read(addr, got, err);
        check_word(what, got, want);
    endtask

    task automatic wait_idle();
        logic [W-1:0] st;
        logic         err;
        st = W'(1) << `HILO_STAT_BUSY;
        while (st[`HILO_STAT_BUSY])
            apb_read(REG_STATUS, st, err);
    endtask

    task automatic load_hilo(input logic [W-1:0] h, input logic [W-1:0] l);
        write_ok(REG_HI, h);
        write_ok(REG_LO, l);
        ref_hi = h;
        ref_lo = l;
    endtask

    // Full operation through the bus, compared with the model.
    task automatic run_op(input funct_t f, input logic [W-1:0] a, input logic [W-1:0] b);
        logic [2*W-1:0] want;
        write_ok(REG_OP1, a);
        write_ok(REG_OP2, b);
        write_ok(REG_CMD, W'(f));
        wait_idle();
        if (f == FUNCT_DIV || f == FUNCT_DIVU)
            want = ref_divide(f, a, b);
        else
            want = ref_mult(f, a, b, {ref_hi, ref_lo});
        read_expect(REG_HI, want[2*W-1:W], $sformatf("%s %h,%h HI", f.name(), a, b));
        read_expect(REG_LO, want[W-1:0], $sformatf("%s %h,%h LO", f.name(), a, b));
        ref_hi = want[2*W-1:W];
        ref_lo = want[W-1:0];
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Directed tests.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic test_reset_state();
        read_expect(REG_STATUS, '0, "STATUS after reset");
        read_expect(REG_HI, '0, "HI after reset");
        read_expect(REG_LO, '0, "LO after reset");
        read_expect(REG_OP1, '0, "OP1 after reset");
        read_expect(REG_OP2, '0, "OP2 after reset");
    endtask

    task automatic test_registers();
        logic [W-1:0] v;
        v = rand_bits(W);
        write_ok(REG_OP1, v);
        read_expect(REG_OP1, v, "OP1 readback");
        v = rand_bits(W);
        write_ok(REG_OP2, v);
        read_expect(REG_OP2, v, "OP2 readback");
        load_hilo(rand_bits(W), rand_bits(W));
        read_expect(REG_HI, ref_hi, "HI readback");
        read_expect(REG_LO, ref_lo, "LO readback");
        write_ok(REG_CMD, W'(FUNCT_NONE));          // Accepted, nothing starts.
        read_expect(REG_STATUS, '0, "STATUS after FUNCT_NONE");
        write_ok(REG_CMD, 32'h0000_000f);
        read_expect(REG_STATUS, '0, "STATUS after undefined code");
        read_expect(REG_CMD, '0, "CMD read");
        read_expect(REG_HI, ref_hi, "HI after ignored commands");
    endtask

    task automatic test_mult();
        logic [W-1:0] ca [N_MULT_CORNER] = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000,
                                             32'h8000_0000, 32'h7fff_ffff};
        logic [W-1:0] cb [N_MULT_CORNER] = '{32'hffff_ffff, 32'hffff_ffff, 32'h8000_0000,
                                             32'hffff_ffff, 32'h8000_0000};
        logic [W-1:0] a;
        logic [W-1:0] b;
        for (int i = 0; i < N_MULT_CORNER; i++) begin
            run_op(FUNCT_MULT, ca[i], cb[i]);
            run_op(FUNCT_MULTU, ca[i], cb[i]);
        end
        for (int i = 0; i < N_MULT_RAND; i++) begin
            a = rand_bits(W);
            b = rand_bits(W);
            run_op(FUNCT_MULT, a, b);
            run_op(FUNCT_MULTU, a, b);
        end
    endtask

    task automatic test_mac();
        funct_t ops [4] = '{FUNCT_MADD, FUNCT_MADDU, FUNCT_MSUB, FUNCT_MSUBU};
        for (int k = 0; k < 4; k++) begin
            for (int i = 0; i < N_MAC; i++) begin
                load_hilo(rand_bits(W), rand_bits(W));
                run_op(ops[k], rand_bits(W), rand_bits(W));
            end
        end
    endtask

    task automatic test_div();
        funct_t       cf [N_DIV_CORNER] = '{FUNCT_DIV, FUNCT_DIVU, FUNCT_DIV, FUNCT_DIV,
                                            FUNCT_DIV, FUNCT_DIV, FUNCT_DIVU};
        logic [W-1:0] ca [N_DIV_CORNER] = '{32'h1234_5678, 32'h8765_4321, 32'h8000_0000,
                                            32'hffff_fff9, 32'h0000_0007, 32'hffff_fff9,
                                            32'hffff_ffff};
        logic [W-1:0] cb [N_DIV_CORNER] = '{32'h0000_0000, 32'h0000_0000, 32'hffff_ffff,
                                            32'h0000_0002, 32'hffff_fffe, 32'hffff_fffe,
                                            32'h0000_0003};
        logic [W-1:0] a;
        logic [W-1:0] b;
        for (int i = 0; i < N_DIV_CORNER; i++)
            run_op(cf[i], ca[i], cb[i]);
        for (int i = 0; i < N_DIV_RAND; i++) begin
            a = rand_bits(W);
            b = rand_bits(W) >> rand_bits(5);       // Spread the quotient size.
            if (lfsr_bit())
                b = -b;
            run_op(FUNCT_DIV, a, b);
            run_op(FUNCT_DIVU, a, b);
        end
    endtask

    task automatic test_backpressure();
        logic [W-1:0]   a;
        logic [W-1:0]   b;
        logic [2*W-1:0] want;
        a = rand_bits(W);
        b = rand_bits(12) | 32'h1;
        want = ref_divide(FUNCT_DIV, a, b);
        write_ok(REG_OP1, a);
        write_ok(REG_OP2, b);
        write_ok(REG_CMD, W'(FUNCT_DIV));
        write_refused(REG_CMD, W'(FUNCT_MULT));
        write_refused(REG_HI, ~a);
        write_refused(REG_LO, a ^ b);
        read_expect(REG_STATUS, 32'h3, "STATUS while busy after refused writes");
        read_expect(REG_HI, ref_hi, "HI while busy");   // Still the old value.
        read_expect(REG_LO, ref_lo, "LO while busy");
        wait_idle();
        read_expect(REG_HI, want[2*W-1:W], "HI after refused writes");
        read_expect(REG_LO, want[W-1:0], "LO after refused writes");
        ref_hi = want[2*W-1:W];
        ref_lo = want[W-1:0];
        read_expect(REG_STATUS, 32'h2, "STATUS error flag sticky");
        write_ok(REG_STATUS, '0);
        read_expect(REG_STATUS, '0, "STATUS after clear");
    endtask

    // The first read after the command lands three cycles after its access edge.
    task automatic test_mult_timing();
        logic [W-1:0]   a;
        logic [W-1:0]   b;
        logic [2*W-1:0] want;
        a = rand_bits(W);
        b = rand_bits(W);
        want = ref_mult(FUNCT_MULT, a, b, {ref_hi, ref_lo});
        write_ok(REG_OP1, a);
        write_ok(REG_OP2, b);
        write_ok(REG_CMD, W'(FUNCT_MULT));
        read_expect(REG_HI, want[2*W-1:W], "HI three cycles after MULT");
        read_expect(REG_LO, want[W-1:0], "LO after MULT");
        read_expect(REG_STATUS, '0, "STATUS after MULT");
        ref_hi = want[2*W-1:W];
        ref_lo = want[W-1:0];
    endtask

    initial begin
        rst     = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b1;
        test_reset_state();
        test_registers();
        test_mult();
        test_mac();
        test_div();
        test_backpressure();
        test_mult_timing();
        $display("Test OK");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired, the run timed out before the tests completed");
        $display("Test FAILED");
        $fatal(1, "Timeout");
    end

endmodule

// ==== rtl/hilo_unit_top.sv ====
`include "hilo_defines.svh"

module hilo_unit_top (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [`HILO_ADDR_W-1:0]     paddr,
    input  logic [`HILO_DATA_W-1:0]     pwdata,
    output logic [`HILO_DATA_W-1:0]     prdata,
    output logic                        pready,
    output logic                        pslverr
);

    hilo_exec_if exec_bus ();

    logic [`HILO_DATA_W-1:0]    hi;
    logic [`HILO_DATA_W-1:0]    lo;
    logic                       wb_done;
    logic                       host_wr_hi;
    logic                       host_wr_lo;
    logic [`HILO_DATA_W-1:0]    host_wdata;
    logic                       mult_valid;
    logic [2*`HILO_DATA_W-1:0]  mult_result;
    logic                       div_valid;
    logic [`HILO_DATA_W-1:0]    div_quotient;
    logic [`HILO_DATA_W-1:0]    div_remainder;

    apb_hilo_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .exec       (exec_bus.issue),
        .hi         (hi),
        .lo         (lo),
        .wb_done    (wb_done),
        .host_wr_hi (host_wr_hi),
        .host_wr_lo (host_wr_lo),
        .host_wdata (host_wdata)
    );

    multiplier u_mult (
        .clk         (clk),
        .rst         (rst),
        .exec        (exec_bus.exec),
        .hi          (hi),
        .lo          (lo),
        .mult_valid  (mult_valid),
        .mult_result (mult_result)
    );

    divider u_div (
        .clk           (clk),
        .rst           (rst),
        .exec          (exec_bus.exec),
        .div_valid     (div_valid),
        .div_quotient  (div_quotient),
        .div_remainder (div_remainder)
    );

    hilo_writeback u_wb (
        .clk           (clk),
        .rst           (rst),
        .mult_valid    (mult_valid),
        .mult_result   (mult_result),
        .div_valid     (div_valid),
        .div_quotient  (div_quotient),
        .div_remainder (div_remainder),
        .host_wr_hi    (host_wr_hi),
        .host_wr_lo    (host_wr_lo),
        .host_wdata    (host_wdata),
        .hi            (hi),
        .lo            (lo),
        .wb_done       (wb_done)
    );

endmodule

// ==== rtl/hilo_writeback.sv ====
`include "hilo_defines.svh"

module hilo_writeback (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        mult_valid,
    input  logic [2*`HILO_DATA_W-1:0]   mult_result,

    input  logic                        div_valid,
    input  logic [`HILO_DATA_W-1:0]     div_quotient,
    input  logic [`HILO_DATA_W-1:0]     div_remainder,

    input  logic                        host_wr_hi,
    input  logic                        host_wr_lo,
    input  logic [`HILO_DATA_W-1:0]     host_wdata,

    output logic [`HILO_DATA_W-1:0]     hi,
    output logic [`HILO_DATA_W-1:0]     lo,
    output logic                        wb_done
);

    // Busy drops on the same edge that loads HI/LO.
    assign wb_done = mult_valid || div_valid;

    always_ff @(posedge clk) begin
        if (!rst) begin
            hi <= '0;
            lo <= '0;
        end else if (mult_valid) begin
            hi <= mult_result[2*`HILO_DATA_W-1:`HILO_DATA_W];
            lo <= mult_result[`HILO_DATA_W-1:0];
        end else if (div_valid) begin
            hi <= div_remainder;
            lo <= div_quotient;
        end else begin
            if (host_wr_hi)
                hi <= host_wdata;               // MTHI.
            if (host_wr_lo)
                lo <= host_wdata;               // MTLO.
        end
    end

endmodule

// ==== rtl/divider.sv ====
`include "hilo_defines.svh"

module divider
    import hilo_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,

    hilo_exec_if.exec                   exec,

    output logic                        div_valid,
    output logic [`HILO_DATA_W-1:0]     div_quotient,
    output logic [`HILO_DATA_W-1:0]     div_remainder
);

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_FIX
    } div_state_t;

    div_state_t                 state;
    logic [4:0]                 count;
    logic [`HILO_DATA_W-1:0]    quo;            // Dividend shifts out, quotient in.
    logic [`HILO_DATA_W-1:0]    rem;
    logic [`HILO_DATA_W-1:0]    dvsr;
    logic                       neg_q;
    logic                       neg_r;
    logic                       dvsr_zero;
    logic                       go;
    logic                       is_signed;
    logic [`HILO_DATA_W:0]      rem_shift;
    logic [`HILO_DATA_W:0]      diff;

    assign go        = exec.start && (exec.funct inside {FUNCT_DIV, FUNCT_DIVU});
    assign is_signed = (exec.funct == FUNCT_DIV);

    // One restoring step.
    assign rem_shift = {rem, quo[`HILO_DATA_W-1]};
    assign diff      = rem_shift - {1'b0, dvsr};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!rst) begin
            state     <= DIV_IDLE;
            count     <= '0;
            div_valid <= 1'b0;
        end else begin
            div_valid <= 1'b0;
            case (state)
                DIV_IDLE: begin
                    if (go) begin
                        state <= DIV_RUN;
                        count <= '0;
                    end
                end
                DIV_RUN: begin
                    count <= count + 5'd1;
                    if (count == 5'd31)
                        state <= DIV_FIX;
                end
                DIV_FIX: begin
                    state     <= DIV_IDLE;
                    div_valid <= 1'b1;
                end
                default: state <= DIV_IDLE;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Datapath.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (state == DIV_IDLE && go) begin
            quo  <= (is_signed && exec.operand_1[`HILO_DATA_W-1]) ? -exec.operand_1
                                                                   : exec.operand_1;
            dvsr <= (is_signed && exec.operand_2[`HILO_DATA_W-1]) ? -exec.operand_2
                                                                   : exec.operand_2;
            rem       <= '0;
            neg_q     <= is_signed &&
                         (exec.operand_1[`HILO_DATA_W-1] ^ exec.operand_2[`HILO_DATA_W-1]);
            neg_r     <= is_signed && exec.operand_1[`HILO_DATA_W-1];
            dvsr_zero <= (exec.operand_2 == '0);
        end else if (state == DIV_RUN) begin
            if (!diff[`HILO_DATA_W]) begin
                rem <= diff[`HILO_DATA_W-1:0];
                quo <= {quo[`HILO_DATA_W-2:0], 1'b1};
            end else begin
                rem <= rem_shift[`HILO_DATA_W-1:0];
                quo <= {quo[`HILO_DATA_W-2:0], 1'b0};
            end
        end else if (state == DIV_FIX) begin
            // Divide by zero keeps quotient all ones.
            div_quotient  <= (neg_q && !dvsr_zero) ? -quo : quo;
            div_remainder <= neg_r ? -rem : rem;
        end
    end

endmodule

// ==== rtl/multiplier.sv ====
`include "hilo_defines.svh"

module multiplier
    import hilo_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,

    hilo_exec_if.exec                   exec,

    input  logic [`HILO_DATA_W-1:0]     hi,
    input  logic [`HILO_DATA_W-1:0]     lo,

    output logic                        mult_valid,
    output logic [2*`HILO_DATA_W-1:0]   mult_result
);

    logic                           is_mult;
    logic                           is_signed;
    logic                           neg;
    logic [`HILO_DATA_W-1:0]        mcand;
    logic [`HILO_DATA_W-1:0]        mplier;
    logic [2*`HILO_DATA_W-1:0]      prod;
    logic [2*`HILO_DATA_W-1:0]      sprod;
    logic [2*`HILO_DATA_W-1:0]      next_result;

    always_comb begin
        is_mult   = exec.funct inside {FUNCT_MULT, FUNCT_MULTU, FUNCT_MADD,
                                       FUNCT_MADDU, FUNCT_MSUB, FUNCT_MSUBU};
        is_signed = exec.funct inside {FUNCT_MULT, FUNCT_MADD, FUNCT_MSUB};

        // Multiply magnitudes, fix sign afterwards.
        mcand  = (is_signed && exec.operand_1[`HILO_DATA_W-1]) ? -exec.operand_1
                                                                : exec.operand_1;
        mplier = (is_signed && exec.operand_2[`HILO_DATA_W-1]) ? -exec.operand_2
                                                                : exec.operand_2;
        prod   = mcand * mplier;
        neg    = is_signed &&
                 (exec.operand_1[`HILO_DATA_W-1] ^ exec.operand_2[`HILO_DATA_W-1]);
        sprod  = neg ? -prod : prod;

        case (exec.funct)
            FUNCT_MADD, FUNCT_MADDU:    next_result = {hi, lo} + sprod;
            FUNCT_MSUB, FUNCT_MSUBU:    next_result = {hi, lo} - sprod;
            default:                    next_result = sprod;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst)
            mult_valid <= 1'b0;
        else
            mult_valid <= exec.start && is_mult;
    end

    always_ff @(posedge clk) begin
        if (exec.start && is_mult)
            mult_result <= next_result;     // HI/LO sampled here.
    end

endmodule

// ==== rtl/apb_hilo_regs.sv ====
`include "hilo_defines.svh"

module apb_hilo_regs
    import hilo_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [`HILO_ADDR_W-1:0]     paddr,
    input  logic [`HILO_DATA_W-1:0]     pwdata,
    output logic [`HILO_DATA_W-1:0]     prdata,
    output logic                        pready,
    output logic                        pslverr,

    hilo_exec_if.issue                  exec,

    input  logic [`HILO_DATA_W-1:0]     hi,
    input  logic [`HILO_DATA_W-1:0]     lo,
    input  logic                        wb_done,

    output logic                        host_wr_hi,
    output logic                        host_wr_lo,
    output logic [`HILO_DATA_W-1:0]     host_wdata
);

    logic [`HILO_DATA_W-1:0]    op1;
    logic [`HILO_DATA_W-1:0]    op2;
    logic [`HILO_DATA_W-1:0]    status;
    logic                       busy;
    logic                       err;
    logic                       start_q;
    funct_t                     funct_q;
    logic                       wr;
    logic                       guarded;
    logic                       cmd_legal;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Access decode.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign wr        = psel && penable && pwrite;
    assign guarded   = (paddr == REG_CMD) || (paddr == REG_HI) || (paddr == REG_LO);
    assign cmd_legal = (pwdata[`HILO_DATA_W-1:4] == '0) &&
                       (pwdata[3:0] >= FUNCT_MULT) && (pwdata[3:0] <= FUNCT_DIVU);

    assign pready     = 1'b1;                   // Zero wait states.
    assign pslverr    = wr && guarded && busy;
    assign host_wr_hi = wr && (paddr == REG_HI) && !busy;
    assign host_wr_lo = wr && (paddr == REG_LO) && !busy;
    assign host_wdata = pwdata;

    assign exec.start     = start_q;
    assign exec.funct     = funct_q;
    assign exec.operand_1 = op1;
    assign exec.operand_2 = op2;

    always_ff @(posedge clk) begin
        if (!rst) begin
            op1     <= '0;
            op2     <= '0;
            busy    <= 1'b0;
            err     <= 1'b0;
            start_q <= 1'b0;
            funct_q <= FUNCT_NONE;
        end else begin
            start_q <= 1'b0;
            if (wb_done)
                busy <= 1'b0;
            if (wr) begin
                case (paddr)
                    REG_OP1:    op1 <= pwdata;
                    REG_OP2:    op2 <= pwdata;
                    REG_CMD: begin
                        if (busy) begin
                            err <= 1'b1;
                        end else if (cmd_legal) begin
                            start_q <= 1'b1;
                            funct_q <= funct_t'(pwdata[3:0]);
                            busy    <= 1'b1;
                        end
                    end
                    REG_HI, REG_LO: begin
                        if (busy)
                            err <= 1'b1;        // Data itself is dropped.
                    end
                    REG_STATUS: err <= 1'b0;
                    default: ;
                endcase
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read mux.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        status                  = '0;
        status[`HILO_STAT_BUSY] = busy;
        status[`HILO_STAT_ERR]  = err;
        case (paddr)
            REG_OP1:    prdata = op1;
            REG_OP2:    prdata = op2;
            REG_STATUS: prdata = status;
            REG_HI:     prdata = hi;
            REG_LO:     prdata = lo;
            default:    prdata = '0;            // CMD and holes.
        endcase
    end

endmodule

// ==== rtl/hilo_exec_if.sv ====
`include "hilo_defines.svh"

interface hilo_exec_if
    import hilo_pkg::*;
();

    logic                       start;      // One cycle pulse.
    funct_t                     funct;
    logic [`HILO_DATA_W-1:0]    operand_1;
    logic [`HILO_DATA_W-1:0]    operand_2;

    modport issue (
        output start,
        output funct,
        output operand_1,
        output operand_2
    );

    modport exec (
        input  start,
        input  funct,
        input  operand_1,
        input  operand_2
    );

endinterface

// ==== rtl/hilo_pkg.sv ====
`include "hilo_defines.svh"

package hilo_pkg;

    // Function codes written to REG_CMD.
    typedef enum logic [3:0] {
        FUNCT_NONE  = 4'd0,
        FUNCT_MULT  = 4'd1,
        FUNCT_MULTU = 4'd2,
        FUNCT_MADD  = 4'd3,
        FUNCT_MADDU = 4'd4,
        FUNCT_MSUB  = 4'd5,
        FUNCT_MSUBU = 4'd6,
        FUNCT_DIV   = 4'd7,
        FUNCT_DIVU  = 4'd8
    } funct_t;

    // APB word offsets.
    typedef enum logic [`HILO_ADDR_W-1:0] {
        REG_OP1    = 5'h00,
        REG_OP2    = 5'h04,
        REG_CMD    = 5'h08,     // Write only.
        REG_STATUS = 5'h0C,
        REG_HI     = 5'h10,
        REG_LO     = 5'h14
    } reg_addr_t;

endpackage

// ==== rtl/hilo_defines.svh ====
`ifndef HILO_DEFINES_SVH
`define HILO_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Datapath widths.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define HILO_DATA_W     32      // Operand and HI/LO width.
`define HILO_ADDR_W     5       // APB byte address width.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// STATUS register layout.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define HILO_STAT_BUSY  0       // Operation in flight.
`define HILO_STAT_ERR   1       // Sticky flag for a write while busy.

`endif
